/* include/issue_cfg.svh */
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// Reservation station
`define ISSUE_RS_SZ      8
`define ISSUE_RS_IDX_W   3

// Functional units and completion bus
`define ISSUE_NUM_ALU    2
`define ISSUE_NUM_MULT   2
`define ISSUE_NUM_CDB    2

// Physical register file
`define ISSUE_PHYS_REGS  64
`define ISSUE_PREG_W     6

// Datapath widths
`define ISSUE_XLEN       32
`define ISSUE_BMASK_W    4
`define ISSUE_ALU_FUNC_W 4

`endif

/* rtl/issue_pkg.sv */
`default_nettype none

`include "issue_cfg.svh"

package issue_pkg;

    typedef logic [`ISSUE_PREG_W-1:0] preg_idx_t;
    typedef logic [`ISSUE_XLEN-1:0]   data_t;

    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_type_e;

    // Register-register encoding, used for the multiply function
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // Immediate encoding, used for the ALU second operand
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } inst_word_u;

    typedef struct packed {
        logic                         valid;
        fu_type_e                     fu_type;
        preg_idx_t                    src1;
        logic                         src1_ready;
        preg_idx_t                    src2;
        logic                         src2_ready;
        preg_idx_t                    dest;
        logic [`ISSUE_BMASK_W-1:0]    b_mask;
        inst_word_u                   inst;
        data_t                        pc;
        logic [`ISSUE_ALU_FUNC_W-1:0] alu_func;
        logic                         opb_is_imm;
    } rs_entry_t;

    typedef struct packed {
        logic      valid;
        preg_idx_t tag;
        data_t     result;
    } cdb_entry_t;

    typedef struct packed {
        logic                         valid;
        data_t                        pc;
        logic [`ISSUE_ALU_FUNC_W-1:0] alu_func;
        preg_idx_t                    dest;
        data_t                        opa;
        data_t                        opb;
    } alu_packet_t;

    typedef struct packed {
        logic                      valid;
        logic [2:0]                mult_func;
        preg_idx_t                 dest;
        logic [`ISSUE_BMASK_W-1:0] b_mask;
        data_t                     opa;
        data_t                     opb;
    } mult_packet_t;

endpackage

`default_nettype wire

/* rtl/prio_select.sv */
`default_nettype none

// Grants the lowest set request bits to the lanes in order, lane 0 first
module prio_select #(
    parameter int WIDTH = 8,
    parameter int LANES = 2,
    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic [WIDTH-1:0]             req,
    output logic [LANES-1:0][WIDTH-1:0]  gnt,
    output logic [LANES-1:0][IDX_W-1:0]  gnt_idx,
    output logic [LANES-1:0]             gnt_valid
);

    always_comb begin
        logic [WIDTH-1:0] remaining;
        remaining = req;
        gnt       = '0;
        gnt_idx   = '0;
        gnt_valid = '0;
        for (int k = 0; k < LANES; k++) begin
            // Scan downward so the lowest set bit is the last one written
            for (int b = WIDTH - 1; b >= 0; b--) begin
                if (remaining[b]) begin
                    gnt[k]     = '0;
                    gnt[k][b]  = 1'b1;
                    gnt_idx[k] = IDX_W'(b);
                    gnt_valid[k] = 1'b1;
                end
            end
            // Bit taken by this lane drops out for the later lanes
            remaining = remaining & ~gnt[k];
        end
    end

    // Two lanes holding the same request would issue one entry twice
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            for (int m = k + 1; m < LANES; m++) begin
                assert final ((gnt[k] & gnt[m]) == '0)
                    else $error("prio_select: lanes %0d and %0d share grant %b",
                                k, m, gnt[k] & gnt[m]);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/operand_bypass.sv */
`default_nettype none

`include "issue_cfg.svh"

module operand_bypass (
    input  issue_pkg::preg_idx_t                        tag,
    input  logic [`ISSUE_PHYS_REGS-1:0]                 complete_list,
    input  issue_pkg::data_t                            rf_data,
    input  issue_pkg::cdb_entry_t [`ISSUE_NUM_CDB-1:0]  cdb,
    input  issue_pkg::cdb_entry_t [`ISSUE_NUM_CDB-1:0]  next_cdb,
    output issue_pkg::data_t                            operand
);

    issue_pkg::cdb_entry_t cdb_hit;
    issue_pkg::cdb_entry_t next_hit;

    // Returns the highest matching slot of one bus, valid low on a miss
    function automatic issue_pkg::cdb_entry_t scan_bus(
        input issue_pkg::cdb_entry_t [`ISSUE_NUM_CDB-1:0] bus,
        input issue_pkg::preg_idx_t                       match_tag
    );
        issue_pkg::cdb_entry_t hit;
        hit = '0;
        for (int j = 0; j < `ISSUE_NUM_CDB; j++) begin
            if (bus[j].valid && bus[j].tag == match_tag) begin
                hit = bus[j];
            end
        end
        return hit;
    endfunction

    assign cdb_hit  = scan_bus(cdb, tag);
    assign next_hit = scan_bus(next_cdb, tag);

    // Complete list first, then the current bus, then the one after it
    always_comb begin
        if (complete_list[tag]) begin
            operand = rf_data;
        end else if (cdb_hit.valid) begin
            operand = cdb_hit.result;
        end else if (next_hit.valid) begin
            operand = next_hit.result;
        end else begin
            operand = '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/issue_select.sv */
`default_nettype none

`include "issue_cfg.svh"

module issue_select (
    input  issue_pkg::rs_entry_t [`ISSUE_RS_SZ-1:0]          rs_entries,
    input  logic [`ISSUE_NUM_MULT-1:0]                       mult_free,
    input  logic [`ISSUE_NUM_MULT-1:0]                       mult_cdb_req,
    output logic [`ISSUE_RS_SZ-1:0]                          rs_issuing,
    output logic [`ISSUE_NUM_MULT-1:0]                       mult_cdb_gnt,
    output logic [`ISSUE_NUM_ALU-1:0]                        alu_issue,
    output logic [`ISSUE_NUM_ALU-1:0][`ISSUE_RS_IDX_W-1:0]   alu_idx,
    output logic [`ISSUE_NUM_MULT-1:0]                       mult_issue,
    output logic [`ISSUE_NUM_MULT-1:0][`ISSUE_RS_IDX_W-1:0]  mult_idx
);

    localparam int MULT_IDX_W = (`ISSUE_NUM_MULT > 1) ? $clog2(`ISSUE_NUM_MULT) : 1;
    localparam int SLOT_W     = `ISSUE_NUM_MULT + `ISSUE_NUM_ALU;

    logic [`ISSUE_RS_SZ-1:0] ready;
    logic [`ISSUE_RS_SZ-1:0] alu_req;
    logic [`ISSUE_RS_SZ-1:0] mult_req;

    logic [`ISSUE_NUM_ALU-1:0][`ISSUE_RS_SZ-1:0]       alu_gnt;
    logic [`ISSUE_NUM_ALU-1:0]                         alu_valid;
    logic [`ISSUE_NUM_MULT-1:0][`ISSUE_RS_SZ-1:0]      mult_gnt;
    logic [`ISSUE_NUM_MULT-1:0][`ISSUE_RS_IDX_W-1:0]   mult_cand_idx;
    logic [`ISSUE_NUM_MULT-1:0]                        mult_cand_valid;
    logic [`ISSUE_NUM_MULT-1:0][MULT_IDX_W-1:0]        fu_idx;
    logic [`ISSUE_NUM_MULT-1:0]                        fu_valid;
    logic [`ISSUE_NUM_CDB-1:0][SLOT_W-1:0]             slot_gnt_lanes;
    logic [SLOT_W-1:0]                                 slot_gnt;
    logic [`ISSUE_RS_SZ-1:0]                           alu_taken;
    logic [`ISSUE_RS_SZ-1:0]                           mult_taken;

    always_comb begin
        for (int i = 0; i < `ISSUE_RS_SZ; i++) begin
            ready[i]    = rs_entries[i].valid && rs_entries[i].src1_ready &&
                          rs_entries[i].src2_ready;
            alu_req[i]  = ready[i] && (rs_entries[i].fu_type == issue_pkg::FU_ALU);
            mult_req[i] = ready[i] && (rs_entries[i].fu_type == issue_pkg::FU_MULT);
        end
    end

    prio_select #(.WIDTH(`ISSUE_RS_SZ), .LANES(`ISSUE_NUM_ALU)) u_alu_select (
        .req       (alu_req),
        .gnt       (alu_gnt),
        .gnt_idx   (alu_idx),
        .gnt_valid (alu_valid)
    );

    prio_select #(.WIDTH(`ISSUE_RS_SZ), .LANES(`ISSUE_NUM_MULT)) u_mult_select (
        .req       (mult_req),
        .gnt       (mult_gnt),
        .gnt_idx   (mult_cand_idx),
        .gnt_valid (mult_cand_valid)
    );

    prio_select #(.WIDTH(`ISSUE_NUM_MULT), .LANES(`ISSUE_NUM_MULT)) u_unit_select (
        .req       (mult_free),
        .gnt       (),
        .gnt_idx   (fu_idx),
        .gnt_valid (fu_valid)
    );

    // Finishing multiplies sit in the low bits and win the slots first
    prio_select #(.WIDTH(SLOT_W), .LANES(`ISSUE_NUM_CDB)) u_slot_select (
        .req       ({alu_valid, mult_cdb_req}),
        .gnt       (slot_gnt_lanes),
        .gnt_idx   (),
        .gnt_valid ()
    );

    always_comb begin
        slot_gnt = '0;
        for (int s = 0; s < `ISSUE_NUM_CDB; s++) begin
            slot_gnt = slot_gnt | slot_gnt_lanes[s];
        end
    end

    assign mult_cdb_gnt = slot_gnt[`ISSUE_NUM_MULT-1:0];
    assign alu_issue    = alu_valid & slot_gnt[SLOT_W-1:`ISSUE_NUM_MULT];

    always_comb begin
        alu_taken = '0;
        for (int k = 0; k < `ISSUE_NUM_ALU; k++) begin
            alu_taken = alu_taken | (alu_gnt[k] & {`ISSUE_RS_SZ{alu_issue[k]}});
        end
    end

    // k-th multiply candidate goes to the k-th free unit
    always_comb begin
        mult_issue = '0;
        mult_idx   = '0;
        mult_taken = '0;
        for (int k = 0; k < `ISSUE_NUM_MULT; k++) begin
            if (mult_cand_valid[k] && fu_valid[k]) begin
                mult_issue[fu_idx[k]] = 1'b1;
                mult_idx[fu_idx[k]]   = mult_cand_idx[k];
                mult_taken            = mult_taken | mult_gnt[k];
            end
        end
    end

    assign rs_issuing = alu_taken | mult_taken;

    always_comb begin
        assert final ((rs_issuing & ~ready) == '0)
            else $error("issue_select: issuing entries %b not ready", rs_issuing & ~ready);
        assert final ((mult_issue & ~mult_free) == '0)
            else $error("issue_select: issue to busy multiplier %b", mult_issue & ~mult_free);
    end

endmodule

`default_nettype wire

/* rtl/packet_build.sv */
`default_nettype none

`include "issue_cfg.svh"

module packet_build (
    input  logic                                               clock,
    input  logic                                               reset,
    input  issue_pkg::rs_entry_t [`ISSUE_RS_SZ-1:0]            rs_entries,
    input  logic [`ISSUE_NUM_ALU-1:0]                          alu_issue,
    input  logic [`ISSUE_NUM_ALU-1:0][`ISSUE_RS_IDX_W-1:0]     alu_idx,
    input  logic [`ISSUE_NUM_MULT-1:0]                         mult_issue,
    input  logic [`ISSUE_NUM_MULT-1:0][`ISSUE_RS_IDX_W-1:0]    mult_idx,
    input  logic [`ISSUE_PHYS_REGS-1:0]                        complete_list,
    input  issue_pkg::cdb_entry_t [`ISSUE_NUM_CDB-1:0]         cdb,
    input  issue_pkg::cdb_entry_t [`ISSUE_NUM_CDB-1:0]         next_cdb,
    input  issue_pkg::data_t [`ISSUE_NUM_ALU-1:0][1:0]         alu_read_data,
    input  issue_pkg::data_t [`ISSUE_NUM_MULT-1:0][1:0]        mult_read_data,
    output issue_pkg::preg_idx_t [`ISSUE_NUM_ALU-1:0][1:0]     alu_read_idx,
    output issue_pkg::preg_idx_t [`ISSUE_NUM_MULT-1:0][1:0]    mult_read_idx,
    output issue_pkg::alu_packet_t [`ISSUE_NUM_ALU-1:0]        alu_packets,
    output issue_pkg::mult_packet_t [`ISSUE_NUM_MULT-1:0]      mult_packets
);

    // ALU lanes, index 0 of each read pair is source 1
    for (genvar k = 0; k < `ISSUE_NUM_ALU; k++) begin : g_alu
        issue_pkg::rs_entry_t             entry;
        issue_pkg::data_t [1:0]           operand;
        issue_pkg::data_t                 imm;
        issue_pkg::alu_packet_t           packet_next;

        assign entry = rs_entries[alu_idx[k]];
        assign alu_read_idx[k][0] = alu_issue[k] ? entry.src1 : '0;
        assign alu_read_idx[k][1] = alu_issue[k] ? entry.src2 : '0;

        for (genvar op = 0; op < 2; op++) begin : g_op
            operand_bypass u_bypass (
                .tag           ((op == 0) ? entry.src1 : entry.src2),
                .complete_list (complete_list),
                .rf_data       (alu_read_data[k][op]),
                .cdb           (cdb),
                .next_cdb      (next_cdb),
                .operand       (operand[op])
            );
        end

        assign imm = {{(`ISSUE_XLEN-12){entry.inst.i_view.imm12[11]}},
                      entry.inst.i_view.imm12};

        always_comb begin
            packet_next.valid    = alu_issue[k];
            packet_next.pc       = entry.pc;
            packet_next.alu_func = entry.alu_func;
            packet_next.dest     = entry.dest;
            packet_next.opa      = operand[0];
            packet_next.opb      = entry.opb_is_imm ? imm : operand[1];
        end

        always_ff @(posedge clock) begin
            alu_packets[k] <= packet_next;
            if (reset) begin
                alu_packets[k].valid <= 1'b0;
            end
        end

        // A packet only appears the cycle after its lane won an issue
        assert property (@(posedge clock) disable iff (reset)
            alu_packets[k].valid |-> $past(alu_issue[k]))
            else $error("packet_build: ALU lane %0d valid without issue", k);
    end

    // Multiplier lanes are indexed by unit
    for (genvar u = 0; u < `ISSUE_NUM_MULT; u++) begin : g_mult
        issue_pkg::rs_entry_t             entry;
        issue_pkg::data_t [1:0]           operand;
        issue_pkg::mult_packet_t          packet_next;

        assign entry = rs_entries[mult_idx[u]];
        assign mult_read_idx[u][0] = mult_issue[u] ? entry.src1 : '0;
        assign mult_read_idx[u][1] = mult_issue[u] ? entry.src2 : '0;

        for (genvar op = 0; op < 2; op++) begin : g_op
            operand_bypass u_bypass (
                .tag           ((op == 0) ? entry.src1 : entry.src2),
                .complete_list (complete_list),
                .rf_data       (mult_read_data[u][op]),
                .cdb           (cdb),
                .next_cdb      (next_cdb),
                .operand       (operand[op])
            );
        end

        always_comb begin
            packet_next.valid     = mult_issue[u];
            packet_next.mult_func = entry.inst.r_view.funct3;
            packet_next.dest      = entry.dest;
            packet_next.b_mask    = entry.b_mask;
            packet_next.opa       = operand[0];
            packet_next.opb       = operand[1];
        end

        always_ff @(posedge clock) begin
            mult_packets[u] <= packet_next;
            if (reset) begin
                mult_packets[u].valid <= 1'b0;
            end
        end

        assert property (@(posedge clock) disable iff (reset)
            mult_packets[u].valid |-> $past(mult_issue[u]))
            else $error("packet_build: multiplier %0d valid without issue", u);
    end

endmodule

`default_nettype wire

/* rtl/issue_stage.sv */
`default_nettype none

`include "issue_cfg.svh"

module issue_stage (
    input  logic                                               clock,
    input  logic                                               reset,
    input  issue_pkg::rs_entry_t [`ISSUE_RS_SZ-1:0]            rs_entries,
    input  logic [`ISSUE_PHYS_REGS-1:0]                        complete_list,
    input  issue_pkg::cdb_entry_t [`ISSUE_NUM_CDB-1:0]         cdb,
    input  issue_pkg::cdb_entry_t [`ISSUE_NUM_CDB-1:0]         next_cdb,
    input  issue_pkg::data_t [`ISSUE_NUM_ALU-1:0][1:0]         alu_read_data,
    input  issue_pkg::data_t [`ISSUE_NUM_MULT-1:0][1:0]        mult_read_data,
    input  logic [`ISSUE_NUM_MULT-1:0]                         mult_free,
    input  logic [`ISSUE_NUM_MULT-1:0]                         mult_cdb_req,
    output logic [`ISSUE_RS_SZ-1:0]                            rs_issuing,
    output logic [`ISSUE_NUM_MULT-1:0]                         mult_cdb_gnt,
    output issue_pkg::preg_idx_t [`ISSUE_NUM_ALU-1:0][1:0]     alu_read_idx,
    output issue_pkg::preg_idx_t [`ISSUE_NUM_MULT-1:0][1:0]    mult_read_idx,
    output issue_pkg::alu_packet_t [`ISSUE_NUM_ALU-1:0]        alu_packets,
    output issue_pkg::mult_packet_t [`ISSUE_NUM_MULT-1:0]      mult_packets
);

    // Issue decisions passed from selection to the packet registers
    logic [`ISSUE_NUM_ALU-1:0]                         alu_issue;
    logic [`ISSUE_NUM_ALU-1:0][`ISSUE_RS_IDX_W-1:0]    alu_idx;
    logic [`ISSUE_NUM_MULT-1:0]                        mult_issue;
    logic [`ISSUE_NUM_MULT-1:0][`ISSUE_RS_IDX_W-1:0]   mult_idx;

    issue_select u_issue_select (
        .rs_entries   (rs_entries),
        .mult_free    (mult_free),
        .mult_cdb_req (mult_cdb_req),
        .rs_issuing   (rs_issuing),
        .mult_cdb_gnt (mult_cdb_gnt),
        .alu_issue    (alu_issue),
        .alu_idx      (alu_idx),
        .mult_issue   (mult_issue),
        .mult_idx     (mult_idx)
    );

    packet_build u_packet_build (
        .clock          (clock),
        .reset          (reset),
        .rs_entries     (rs_entries),
        .alu_issue      (alu_issue),
        .alu_idx        (alu_idx),
        .mult_issue     (mult_issue),
        .mult_idx       (mult_idx),
        .complete_list  (complete_list),
        .cdb            (cdb),
        .next_cdb       (next_cdb),
        .alu_read_data  (alu_read_data),
        .mult_read_data (mult_read_data),
        .alu_read_idx   (alu_read_idx),
        .mult_read_idx  (mult_read_idx),
        .alu_packets    (alu_packets),
        .mult_packets   (mult_packets)
    );

endmodule

`default_nettype wire

/* test/issue_tb.sv */
`default_nettype none

`include "issue_cfg.svh"

module issue_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ENTRY_W = $bits(issue_pkg::rs_entry_t);
    localparam int CDB_W   = $bits(issue_pkg::cdb_entry_t);
    localparam int NUM_RUN = 2000;

    logic                                            clock = 1'b0;
    logic                                            reset;
    issue_pkg::rs_entry_t [`ISSUE_RS_SZ-1:0]         rs_entries;
    logic [`ISSUE_PHYS_REGS-1:0]                     complete_list;
    issue_pkg::cdb_entry_t [`ISSUE_NUM_CDB-1:0]      cdb;
    issue_pkg::cdb_entry_t [`ISSUE_NUM_CDB-1:0]      next_cdb;
    issue_pkg::data_t [`ISSUE_NUM_ALU-1:0][1:0]      alu_read_data;
    issue_pkg::data_t [`ISSUE_NUM_MULT-1:0][1:0]     mult_read_data;
    logic [`ISSUE_NUM_MULT-1:0]                      mult_free;
    logic [`ISSUE_NUM_MULT-1:0]                      mult_cdb_req;
    logic [`ISSUE_RS_SZ-1:0]                         rs_issuing;
    logic [`ISSUE_NUM_MULT-1:0]                      mult_cdb_gnt;
    issue_pkg::preg_idx_t [`ISSUE_NUM_ALU-1:0][1:0]  alu_read_idx;
    issue_pkg::preg_idx_t [`ISSUE_NUM_MULT-1:0][1:0] mult_read_idx;
    issue_pkg::alu_packet_t [`ISSUE_NUM_ALU-1:0]     alu_packets;
    issue_pkg::mult_packet_t [`ISSUE_NUM_MULT-1:0]   mult_packets;

    // Register file and model state
    issue_pkg::data_t                                rf [`ISSUE_PHYS_REGS];
    logic [15:0]                                     lfsr;
    logic [`ISSUE_RS_SZ-1:0]                         exp_issuing;
    logic [`ISSUE_NUM_MULT-1:0]                      exp_gnt;
    issue_pkg::alu_packet_t [`ISSUE_NUM_ALU-1:0]     exp_alu;
    issue_pkg::mult_packet_t [`ISSUE_NUM_MULT-1:0]   exp_mult;
    issue_pkg::preg_idx_t [`ISSUE_NUM_ALU-1:0][1:0]  exp_alu_ridx;
    issue_pkg::preg_idx_t [`ISSUE_NUM_MULT-1:0][1:0] exp_mult_ridx;

    issue_stage u_issue_stage (
        .clock          (clock),
        .reset          (reset),
        .rs_entries     (rs_entries),
        .complete_list  (complete_list),
        .cdb            (cdb),
        .next_cdb       (next_cdb),
        .alu_read_data  (alu_read_data),
        .mult_read_data (mult_read_data),
        .mult_free      (mult_free),
        .mult_cdb_req   (mult_cdb_req),
        .rs_issuing     (rs_issuing),
        .mult_cdb_gnt   (mult_cdb_gnt),
        .alu_read_idx   (alu_read_idx),
        .mult_read_idx  (mult_read_idx),
        .alu_packets    (alu_packets),
        .mult_packets   (mult_packets)
    );

    always #4 clock = ~clock;

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
    end

    // Register file answers in the same cycle
    always_comb begin
        for (int k = 0; k < `ISSUE_NUM_ALU; k++) begin
            for (int op = 0; op < 2; op++) begin
                alu_read_data[k][op] = rf[alu_read_idx[k][op]];
            end
        end
        for (int u = 0; u < `ISSUE_NUM_MULT; u++) begin
            for (int op = 0; op < 2; op++) begin
                mult_read_data[u][op] = rf[mult_read_idx[u][op]];
            end
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic take_bits(input int n, output logic [127:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[126:0], lfsr[0]};
        end
    endtask

    task automatic drive_inputs();
        issue_pkg::rs_entry_t [`ISSUE_RS_SZ-1:0]    e;
        issue_pkg::cdb_entry_t [`ISSUE_NUM_CDB-1:0] c;
        issue_pkg::cdb_entry_t [`ISSUE_NUM_CDB-1:0] n;
        logic [127:0]                               r;
        for (int i = 0; i < `ISSUE_RS_SZ; i++) begin
            take_bits(ENTRY_W, r);
            e[i] = issue_pkg::rs_entry_t'(r[ENTRY_W-1:0]);
            // Small tag space so the completion buses hit often
            e[i].src1 = {3'b000, e[i].src1[2:0]};
            e[i].src2 = {3'b000, e[i].src2[2:0]};
            take_bits(2, r);
            e[i].src1_ready = e[i].src1_ready | r[0];
            e[i].src2_ready = e[i].src2_ready | r[1];
        end
        for (int j = 0; j < `ISSUE_NUM_CDB; j++) begin
            take_bits(CDB_W, r);
            c[j] = issue_pkg::cdb_entry_t'(r[CDB_W-1:0]);
            c[j].tag = {3'b000, c[j].tag[2:0]};
            take_bits(CDB_W, r);
            n[j] = issue_pkg::cdb_entry_t'(r[CDB_W-1:0]);
            n[j].tag = {3'b000, n[j].tag[2:0]};
        end
        rs_entries <= e;
        cdb        <= c;
        next_cdb   <= n;
        take_bits(`ISSUE_PHYS_REGS, r);
        complete_list <= r[`ISSUE_PHYS_REGS-1:0];
        take_bits(2 * `ISSUE_NUM_MULT, r);
        mult_free    <= r[`ISSUE_NUM_MULT-1:0];
        mult_cdb_req <= r[2*`ISSUE_NUM_MULT-1:`ISSUE_NUM_MULT];
    endtask

    // Highest slot of the current bus first, then the bus after it
    function automatic issue_pkg::data_t bypass_value(input issue_pkg::preg_idx_t tag);
        if (complete_list[tag]) begin
            return rf[tag];
        end
        for (int j = `ISSUE_NUM_CDB - 1; j >= 0; j--) begin
            if (cdb[j].valid && cdb[j].tag == tag) begin
                return cdb[j].result;
            end
        end
        for (int j = `ISSUE_NUM_CDB - 1; j >= 0; j--) begin
            if (next_cdb[j].valid && next_cdb[j].tag == tag) begin
                return next_cdb[j].result;
            end
        end
        return '0;
    endfunction

    task automatic predict();
        issue_pkg::rs_entry_t e;
        int                   slots;
        int                   lanes;
        int                   cands;
        int                   unit;
        slots         = `ISSUE_NUM_CDB;
        lanes         = 0;
        cands         = 0;
        unit          = 0;
        exp_issuing   = '0;
        exp_gnt       = '0;
        exp_alu       = '0;
        exp_mult      = '0;
        exp_alu_ridx  = '0;
        exp_mult_ridx = '0;
        // Finishing multiplies claim completion slots before new ALU work
        for (int u = 0; u < `ISSUE_NUM_MULT; u++) begin
            if (mult_cdb_req[u] && slots > 0) begin
                exp_gnt[u] = 1'b1;
                slots--;
            end
        end
        for (int i = 0; i < `ISSUE_RS_SZ; i++) begin
            e = rs_entries[i];
            if (e.valid && e.src1_ready && e.src2_ready) begin
                if (e.fu_type == issue_pkg::FU_ALU && lanes < `ISSUE_NUM_ALU) begin
                    if (slots > 0) begin
                        exp_issuing[i]          = 1'b1;
                        exp_alu[lanes].valid    = 1'b1;
                        exp_alu[lanes].pc       = e.pc;
                        exp_alu[lanes].alu_func = e.alu_func;
                        exp_alu[lanes].dest     = e.dest;
                        exp_alu[lanes].opa      = bypass_value(e.src1);
                        exp_alu[lanes].opb      = e.opb_is_imm ?
                            {{20{e.inst[31]}}, e.inst[31:20]} : bypass_value(e.src2);
                        exp_alu_ridx[lanes][0]  = e.src1;
                        exp_alu_ridx[lanes][1]  = e.src2;
                        slots--;
                    end
                    lanes++;
                end else if (e.fu_type == issue_pkg::FU_MULT && cands < `ISSUE_NUM_MULT) begin
                    cands++;
                    // Candidate pairs with the next free unit
                    while (unit < `ISSUE_NUM_MULT && !mult_free[unit]) begin
                        unit++;
                    end
                    if (unit < `ISSUE_NUM_MULT) begin
                        exp_issuing[i]           = 1'b1;
                        exp_mult[unit].valid     = 1'b1;
                        exp_mult[unit].mult_func = e.inst[14:12];
                        exp_mult[unit].dest      = e.dest;
                        exp_mult[unit].b_mask    = e.b_mask;
                        exp_mult[unit].opa       = bypass_value(e.src1);
                        exp_mult[unit].opb       = bypass_value(e.src2);
                        exp_mult_ridx[unit][0]   = e.src1;
                        exp_mult_ridx[unit][1]   = e.src2;
                        unit++;
                    end
                end
            end
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_issuing(input logic [`ISSUE_RS_SZ-1:0] actual,
                                 input logic [`ISSUE_RS_SZ-1:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail rs_issuing: got %h expected %h", actual, expected));
        end
    endtask

    task automatic check_mult_gnt(input logic [`ISSUE_NUM_MULT-1:0] actual,
                                  input logic [`ISSUE_NUM_MULT-1:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail mult_cdb_gnt: got %h expected %h", actual, expected));
        end
    endtask

    task automatic check_read_idx(input string name, input int lane, input int op,
                                  input issue_pkg::preg_idx_t actual,
                                  input issue_pkg::preg_idx_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s[%0d][%0d]: got %h expected %h",
                                name, lane, op, actual, expected));
        end
    endtask

    // Payload only matters when the packet is valid
    task automatic check_alu_packet(input int lane, input issue_pkg::alu_packet_t actual,
                                    input issue_pkg::alu_packet_t expected);
        if (actual.valid !== expected.valid || (expected.valid && actual !== expected)) begin
            abort_run($sformatf("Fail alu_packets[%0d]: got %h expected %h",
                                lane, actual, expected));
        end
    endtask

    task automatic check_mult_packet(input int unit, input issue_pkg::mult_packet_t actual,
                                     input issue_pkg::mult_packet_t expected);
        if (actual.valid !== expected.valid || (expected.valid && actual !== expected)) begin
            abort_run($sformatf("Fail mult_packets[%0d]: got %h expected %h",
                                unit, actual, expected));
        end
    endtask

    task automatic run_cycle();
        @(posedge clock);
        drive_inputs();
        @(negedge clock);
        for (int k = 0; k < `ISSUE_NUM_ALU; k++) begin
            check_alu_packet(k, alu_packets[k], exp_alu[k]);
        end
        for (int u = 0; u < `ISSUE_NUM_MULT; u++) begin
            check_mult_packet(u, mult_packets[u], exp_mult[u]);
        end
        predict();
        check_issuing(rs_issuing, exp_issuing);
        check_mult_gnt(mult_cdb_gnt, exp_gnt);
        // Read indices only matter for lanes that issue this cycle
        for (int k = 0; k < `ISSUE_NUM_ALU; k++) begin
            if (exp_alu[k].valid) begin
                for (int op = 0; op < 2; op++) begin
                    check_read_idx("alu_read_idx", k, op, alu_read_idx[k][op],
                                   exp_alu_ridx[k][op]);
                end
            end
        end
        for (int u = 0; u < `ISSUE_NUM_MULT; u++) begin
            if (exp_mult[u].valid) begin
                for (int op = 0; op < 2; op++) begin
                    check_read_idx("mult_read_idx", u, op, mult_read_idx[u][op],
                                   exp_mult_ridx[u][op]);
                end
            end
        end
        // Reset at the next edge clears every packet
        if (reset) begin
            exp_alu  = '0;
            exp_mult = '0;
        end
    endtask

    initial begin
        int wait_cycles;
        lfsr          = 16'd25402;
        rs_entries    = '0;
        complete_list = '0;
        cdb           = '0;
        next_cdb      = '0;
        mult_free     = '0;
        mult_cdb_req  = '0;
        exp_alu       = '0;
        exp_mult      = '0;
        for (int a = 0; a < `ISSUE_PHYS_REGS; a++) begin
            rf[a] = 32'(a + 1) * 32'h9e37_79b9;
        end
        wait_cycles = 0;
        while (reset !== 1'b0) begin
            run_cycle();
            wait_cycles++;
            if (wait_cycles > 64) begin
                abort_run("Reset was still high after 64 cycles");
            end
        end
        for (int c = 0; c < NUM_RUN; c++) begin
            run_cycle();
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* issue.f */
+incdir+include
rtl/issue_pkg.sv
rtl/prio_select.sv
rtl/operand_bypass.sv
rtl/issue_select.sv
rtl/packet_build.sv
rtl/issue_stage.sv
test/issue_tb.sv

/* Bender.yml */
package:
  name: issue

sources:
  - include_dirs:
      - include
    files:
      - rtl/issue_pkg.sv
      - rtl/prio_select.sv
      - rtl/operand_bypass.sv
      - rtl/issue_select.sv
      - rtl/packet_build.sv
      - rtl/issue_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/issue_tb.sv
